// ==== hdl/xt_bus_pkg.sv ====
//////////////////////////////////////////////////
// Bus widths, I/O port bases and decode targets
// shared by the peripheral glue and its testbench
//////////////////////////////////////////////////

package xt_bus_pkg;

    // CPU bus widths
    parameter int ADDR_WIDTH = 20;
    parameter int DATA_WIDTH = 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Peripheral reached by an I/O cycle
    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_DMA,
        TGT_PIC,
        TGT_PIT,
        TGT_KEYBOARD,
        TGT_DMA_PAGE,
        TGT_EMS
    } io_target_e;

    // Base of each 32-port block below 100h
    parameter logic [15:0] DMA_BASE      = 16'h0000;
    parameter logic [15:0] PIC_BASE      = 16'h0020;
    parameter logic [15:0] PIT_BASE      = 16'h0040;
    parameter logic [15:0] DMA_PAGE_BASE = 16'h0080;

    // Scancode port of the keyboard latch
    parameter logic [15:0] KBD_DATA_PORT = 16'h0060;

endpackage

// ==== hdl/xt_ems_pkg.sv ====
//////////////////////////////////////////////////
// EMS page mapper definitions: page count, map
// width, frame choices and the map array types
//////////////////////////////////////////////////

package xt_ems_pkg;

    parameter int EMS_PAGES     = 4;
    parameter int EMS_MAP_WIDTH = 7;

    // Page registers live at 260h to 263h
    parameter logic [15:0] EMS_PORT_BASE = 16'h0260;

    // Frame segment, decoded to the upper address nibble A, C, D or E
    typedef enum logic [1:0] {
        FRAME_A000,
        FRAME_C000,
        FRAME_D000,
        FRAME_E000
    } ems_frame_e;

    typedef logic [EMS_MAP_WIDTH-1:0] ems_map_t;

    // One map entry per 16 KB window of the frame
    typedef ems_map_t [EMS_PAGES-1:0] ems_map_array_t;

    typedef logic [EMS_PAGES-1:0] ems_window_t;

endpackage

// ==== hdl/io_bus_if.sv ====
//////////////////////////////////////////////////
// CPU I/O bus cycle as seen by the glue modules
// Driven at the top level from the plain ports
//////////////////////////////////////////////////

`timescale 1ns/100ps

interface io_bus_if;

    import xt_bus_pkg::*;

    addr_t address;
    data_t wdata;
    logic  io_read_n;
    logic  io_write_n;
    logic  aen_n;

    // Address decode sees the whole cycle
    modport decoder (
        input address, wdata, io_read_n, io_write_n, aen_n
    );

    // Page registers take address and write data
    modport mapper (
        input address, wdata, io_write_n
    );

    modport reader (
        input io_read_n
    );

endinterface

// ==== hdl/io_decode_if.sv ====
//////////////////////////////////////////////////
// Decoded I/O target and register index, with the
// read and write strobes forwarded alongside
//////////////////////////////////////////////////

`timescale 1ns/100ps

interface io_decode_if;

    import xt_bus_pkg::*;

    io_target_e target;
    logic [1:0] reg_index;
    logic       io_read_n;
    logic       io_write_n;

    // Address decoder side
    modport source (
        output target, reg_index
    );

    // EMS page mapper writes and reads back by index
    modport ems_sink (
        input target, reg_index, io_write_n
    );

    // Read data multiplexer
    modport mux_sink (
        input target, io_read_n
    );

endinterface

// ==== hdl/io_port_decoder.sv ====
//////////////////////////////////////////////////
// I/O address decoder, turning an ISA I/O cycle
// into a target and active-low chip selects
//////////////////////////////////////////////////

`timescale 1ns/100ps

module io_port_decoder (
    io_bus_if.decoder    bus_i,
    input  logic         ems_enabled_i,
    io_decode_if.source  dec_o,
    output logic         dma_cs_n_o,
    output logic         pic_cs_n_o,
    output logic         pit_cs_n_o,
    output logic         dma_page_cs_n_o
);

    import xt_bus_pkg::*;
    import xt_ems_pkg::*;

    io_target_e target;
    logic       ems_hit;
    logic       low_block;

    // EMS registers need a full 16-bit match on 260h to 263h
    assign ems_hit = ems_enabled_i && (bus_i.address[15:2] == EMS_PORT_BASE[15:2]);

    // Motherboard devices sit below 100h
    assign low_block = (bus_i.address[9:8] == 2'b00);

    always_comb begin
        target = TGT_NONE;
        if (!bus_i.aen_n) begin
            if (ems_hit) begin
                target = TGT_EMS;
            end else if (low_block) begin
                if (bus_i.address[9:0] == KBD_DATA_PORT[9:0]) begin
                    target = TGT_KEYBOARD;
                end else begin
                    // One 32-port block per device
                    case (bus_i.address[7:5])
                        DMA_BASE[7:5]:      target = TGT_DMA;
                        PIC_BASE[7:5]:      target = TGT_PIC;
                        PIT_BASE[7:5]:      target = TGT_PIT;
                        DMA_PAGE_BASE[7:5]: target = TGT_DMA_PAGE;
                        default:            target = TGT_NONE;
                    endcase
                end
            end
        end
    end

    assign dec_o.target    = target;
    assign dec_o.reg_index = bus_i.address[1:0];

    // Strobes to the external chips
    assign dma_cs_n_o      = (target != TGT_DMA);
    assign pic_cs_n_o      = (target != TGT_PIC);
    assign pit_cs_n_o      = (target != TGT_PIT);
    assign dma_page_cs_n_o = (target != TGT_DMA_PAGE);

endmodule

// ==== hdl/ems_page_mapper.sv ====
//////////////////////////////////////////////////
// EMS page registers with readback and the four
// 16 KB window hits inside the selected frame
//////////////////////////////////////////////////

`timescale 1ns/100ps

module ems_page_mapper (
    input  logic                        clock,
    input  logic                        reset,
    io_bus_if.mapper                    bus_i,
    io_decode_if.ems_sink               dec_i,
    input  xt_ems_pkg::ems_frame_e      frame_i,
    output xt_ems_pkg::ems_map_array_t  map_o,
    output xt_ems_pkg::ems_window_t     window_o,
    output xt_bus_pkg::data_t           read_data_o
);

    import xt_bus_pkg::*;
    import xt_ems_pkg::*;

    ems_map_array_t         page_map;
    logic [EMS_PAGES-1:0]   page_enable;
    logic [1:0]             page_index;
    logic                   ems_write;
    logic [3:0]             frame_nibble;

    assign page_index = dec_i.reg_index;

    // Write is a level, taken on every clock while qualified
    assign ems_write = (dec_i.target == TGT_EMS) && !dec_i.io_write_n;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            page_map    <= '0;
            page_enable <= '0;
        end else if (ems_write) begin
            if (bus_i.wdata == 8'hFF) begin
                // FFh unmaps the page
                page_map[page_index]    <= '1;
                page_enable[page_index] <= 1'b0;
            end else if (!bus_i.wdata[7]) begin
                page_map[page_index]    <= bus_i.wdata[EMS_MAP_WIDTH-1:0];
                page_enable[page_index] <= 1'b1;
            end
            // 80h to FEh are ignored
        end
    end

    assign map_o = page_map;

    // Unmapped pages read back as FFh
    assign read_data_o = page_enable[page_index] ? {1'b0, page_map[page_index]} : 8'hFF;

    always_comb begin
        case (frame_i)
            FRAME_A000: frame_nibble = 4'hA;
            FRAME_C000: frame_nibble = 4'hC;
            FRAME_D000: frame_nibble = 4'hD;
            default:    frame_nibble = 4'hE;
        endcase
    end

    // Window n covers frame + n * 16 KB
    always_comb begin
        for (int page = 0; page < EMS_PAGES; page++) begin
            window_o[page] = page_enable[page] &&
                (bus_i.address[19:14] == {frame_nibble, 2'(page)});
        end
    end

endmodule

// ==== hdl/keyboard_sync.sv ====
//////////////////////////////////////////////////
// Brings the keyboard scancode and interrupt into
// the bus clock through a reset-cleared shift chain
//////////////////////////////////////////////////

`timescale 1ns/100ps

module keyboard_sync #(
    parameter int KBD_SYNC_STAGES = 2
) (
    input  logic               clock,
    input  logic               reset,
    input  xt_bus_pkg::data_t  keycode_i,
    input  logic               keyboard_irq_i,
    output xt_bus_pkg::data_t  keycode_o,
    output logic               keyboard_irq_o
);

    import xt_bus_pkg::*;

    data_t [KBD_SYNC_STAGES-1:0] keycode_chain;
    logic  [KBD_SYNC_STAGES-1:0] irq_chain;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            keycode_chain <= '0;
            irq_chain     <= '0;
        end else begin
            keycode_chain[0] <= keycode_i;
            irq_chain[0]     <= keyboard_irq_i;
            for (int stage = 1; stage < KBD_SYNC_STAGES; stage++) begin
                keycode_chain[stage] <= keycode_chain[stage-1];
                irq_chain[stage]     <= irq_chain[stage-1];
            end
        end
    end

    // Last stage feeds the 060h read path
    assign keycode_o      = keycode_chain[KBD_SYNC_STAGES-1];
    assign keyboard_irq_o = irq_chain[KBD_SYNC_STAGES-1];

endmodule

// ==== hdl/bus_read_mux.sv ====
//////////////////////////////////////////////////
// Prioritized read data selection onto the CPU
// data bus, with the flag that enables the driver
//////////////////////////////////////////////////

`timescale 1ns/100ps

module bus_read_mux (
    io_decode_if.mux_sink      dec_i,
    input  logic               inta_n_i,
    input  xt_bus_pkg::data_t  pic_data_i,
    input  xt_bus_pkg::data_t  pit_data_i,
    input  xt_bus_pkg::data_t  kbd_data_i,
    input  xt_bus_pkg::data_t  ems_data_i,
    output xt_bus_pkg::data_t  data_o,
    output logic               data_drive_o
);

    import xt_bus_pkg::*;

    logic io_read;

    assign io_read = !dec_i.io_read_n;

    always_comb begin
        data_o       = 8'h00;
        data_drive_o = 1'b1;
        // Interrupt acknowledge wins over any addressed read
        if (!inta_n_i) begin
            data_o = pic_data_i;
        end else if (io_read && (dec_i.target == TGT_PIC)) begin
            data_o = pic_data_i;
        end else if (io_read && (dec_i.target == TGT_PIT)) begin
            data_o = pit_data_i;
        end else if (io_read && (dec_i.target == TGT_KEYBOARD)) begin
            data_o = kbd_data_i;
        end else if (io_read && (dec_i.target == TGT_EMS)) begin
            data_o = ems_data_i;
        end else begin
            // Nobody claims the cycle
            data_drive_o = 1'b0;
        end
    end

endmodule

// ==== hdl/xt_peripheral_glue.sv ====
//////////////////////////////////////////////////
// Top level of the XT peripheral glue: I/O decode,
// EMS mapper, keyboard sync and read data mux
//////////////////////////////////////////////////

`timescale 1ns/100ps

module xt_peripheral_glue #(
    parameter int KBD_SYNC_STAGES = 2
) (
    input  logic                        clock,
    input  logic                        reset,
    input  xt_bus_pkg::addr_t           address_i,
    input  xt_bus_pkg::data_t           data_i,
    input  logic                        io_read_n_i,
    input  logic                        io_write_n_i,
    input  logic                        address_enable_n_i,
    input  logic                        interrupt_acknowledge_n_i,
    input  logic                        ems_enabled_i,
    input  xt_ems_pkg::ems_frame_e      ems_frame_i,
    input  xt_bus_pkg::data_t           pic_data_i,
    input  xt_bus_pkg::data_t           pit_data_i,
    input  xt_bus_pkg::data_t           keycode_i,
    input  logic                        keyboard_irq_i,
    output xt_bus_pkg::data_t           data_o,
    output logic                        data_drive_o,
    output logic                        dma_cs_n_o,
    output logic                        pic_cs_n_o,
    output logic                        pit_cs_n_o,
    output logic                        dma_page_cs_n_o,
    output xt_ems_pkg::ems_map_array_t  ems_map_o,
    output xt_ems_pkg::ems_window_t     ems_window_o,
    output logic                        keyboard_irq_o
);

    import xt_bus_pkg::*;

    data_t kbd_keycode;
    data_t ems_read_data;

    io_bus_if    cpu_bus ();
    io_decode_if io_decode ();

    // CPU cycle onto the internal bus
    assign cpu_bus.address    = address_i;
    assign cpu_bus.wdata      = data_i;
    assign cpu_bus.io_read_n  = io_read_n_i;
    assign cpu_bus.io_write_n = io_write_n_i;
    assign cpu_bus.aen_n      = address_enable_n_i;

    // Strobes travel with the decoded target
    assign io_decode.io_read_n  = cpu_bus.io_read_n;
    assign io_decode.io_write_n = cpu_bus.io_write_n;

    io_port_decoder io_port_decoder_inst (
        .bus_i           (cpu_bus.decoder),
        .ems_enabled_i   (ems_enabled_i),
        .dec_o           (io_decode.source),
        .dma_cs_n_o      (dma_cs_n_o),
        .pic_cs_n_o      (pic_cs_n_o),
        .pit_cs_n_o      (pit_cs_n_o),
        .dma_page_cs_n_o (dma_page_cs_n_o)
    );

    ems_page_mapper ems_page_mapper_inst (
        .clock       (clock),
        .reset       (reset),
        .bus_i       (cpu_bus.mapper),
        .dec_i       (io_decode.ems_sink),
        .frame_i     (ems_frame_i),
        .map_o       (ems_map_o),
        .window_o    (ems_window_o),
        .read_data_o (ems_read_data)
    );

    keyboard_sync #(
        .KBD_SYNC_STAGES (KBD_SYNC_STAGES)
    ) keyboard_sync_inst (
        .clock          (clock),
        .reset          (reset),
        .keycode_i      (keycode_i),
        .keyboard_irq_i (keyboard_irq_i),
        .keycode_o      (kbd_keycode),
        .keyboard_irq_o (keyboard_irq_o)
    );

    bus_read_mux bus_read_mux_inst (
        .dec_i        (io_decode.mux_sink),
        .inta_n_i     (interrupt_acknowledge_n_i),
        .pic_data_i   (pic_data_i),
        .pit_data_i   (pit_data_i),
        .kbd_data_i   (kbd_keycode),
        .ems_data_i   (ems_read_data),
        .data_o       (data_o),
        .data_drive_o (data_drive_o)
    );

endmodule

// ==== verif/xt_peripheral_glue_checker.sv ====
//////////////////////////////////////////////////
// Concurrent assertions bound to the glue top level
// for chip selects, drive during reset and keyboard sync
//////////////////////////////////////////////////

`timescale 1ns/100ps

module xt_peripheral_glue_checker (
    input logic clock_i,
    input logic reset_i,
    input logic dma_cs_n_i,
    input logic pic_cs_n_i,
    input logic pit_cs_n_i,
    input logic dma_page_cs_n_i,
    input logic data_drive_i,
    input logic keyboard_irq_i,
    input logic keyboard_irq_sync_i
);

    // Failed assertions seen so far
    int assertion_failures = 0;

    // Only one external chip may be selected
    assert property (@(posedge clock_i)
        $countones({!dma_cs_n_i, !pic_cs_n_i, !pit_cs_n_i, !dma_page_cs_n_i}) <= 1)
        else begin
            assertion_failures++;
            $error("More than one chip select is low");
        end

    assert property (@(posedge clock_i) reset_i |-> !data_drive_i)
        else begin
            assertion_failures++;
            $error("data_drive_o is high during reset");
        end

    // Two-stage chain from the keyboard receiver
    assert property (@(posedge clock_i) disable iff (reset_i)
        keyboard_irq_sync_i == $past(keyboard_irq_i, 2))
        else begin
            assertion_failures++;
            $error("keyboard_irq_o does not follow keyboard_irq_i by two cycles");
        end

endmodule

bind xt_peripheral_glue xt_peripheral_glue_checker xt_peripheral_glue_checker_inst (
    .clock_i             (clock),
    .reset_i             (reset),
    .dma_cs_n_i          (dma_cs_n_o),
    .pic_cs_n_i          (pic_cs_n_o),
    .pit_cs_n_i          (pit_cs_n_o),
    .dma_page_cs_n_i     (dma_page_cs_n_o),
    .data_drive_i        (data_drive_o),
    .keyboard_irq_i      (keyboard_irq_i),
    .keyboard_irq_sync_i (keyboard_irq_o)
);

// ==== verif/xt_peripheral_glue_tb.sv ====
//////////////////////////////////////////////////
// Testbench for the XT peripheral glue: reads one
// operation per line from verif/glue_tests.txt,
// drives the DUT and compares its outputs
//////////////////////////////////////////////////

`timescale 1ns/100ps

module xt_peripheral_glue_tb;

    import xt_bus_pkg::*;
    import xt_ems_pkg::*;

    localparam int HALF_PERIOD = 50;
    localparam int SETTLE_TIME = 25;
    localparam int IRQ_TIMEOUT = 10;

    typedef enum {IO_WRITE, IO_READ, INTA, MEM_PROBE, KEY, FRAME} op_e;

    logic           clock;
    logic           reset;
    addr_t          address;
    data_t          wdata;
    logic           io_read_n;
    logic           io_write_n;
    logic           aen_n;
    logic           inta_n;
    logic           ems_enabled;
    ems_frame_e     ems_frame;
    data_t          pic_data;
    data_t          pit_data;
    data_t          keycode;
    logic           kbd_irq;
    data_t          rdata;
    logic           data_drive;
    logic           dma_cs_n;
    logic           pic_cs_n;
    logic           pit_cs_n;
    logic           dma_page_cs_n;
    ems_map_array_t ems_map;
    ems_window_t    ems_window;
    logic           kbd_irq_sync;

    int check_count      = 0;
    int mismatch_count   = 0;
    int timeout_count    = 0;
    int file_error_count = 0;

    xt_peripheral_glue #(
        .KBD_SYNC_STAGES (2)
    ) xt_peripheral_glue_inst (
        .clock                     (clock),
        .reset                     (reset),
        .address_i                 (address),
        .data_i                    (wdata),
        .io_read_n_i               (io_read_n),
        .io_write_n_i              (io_write_n),
        .address_enable_n_i        (aen_n),
        .interrupt_acknowledge_n_i (inta_n),
        .ems_enabled_i             (ems_enabled),
        .ems_frame_i               (ems_frame),
        .pic_data_i                (pic_data),
        .pit_data_i                (pit_data),
        .keycode_i                 (keycode),
        .keyboard_irq_i            (kbd_irq),
        .data_o                    (rdata),
        .data_drive_o              (data_drive),
        .dma_cs_n_o                (dma_cs_n),
        .pic_cs_n_o                (pic_cs_n),
        .pit_cs_n_o                (pit_cs_n),
        .dma_page_cs_n_o           (dma_page_cs_n),
        .ems_map_o                 (ems_map),
        .ems_window_o              (ems_window),
        .keyboard_irq_o            (kbd_irq_sync)
    );

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    task automatic check_data(input string name, input data_t got, input data_t expected);
        check_count++;
        if (got !== expected) begin
            mismatch_count++;
            $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic check_window(input string name, input ems_window_t got,
                                input ems_window_t expected);
        check_count++;
        if (got !== expected) begin
            mismatch_count++;
            $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic check_map(input string name, input ems_map_array_t got,
                             input ems_map_array_t expected);
        check_count++;
        if (got !== expected) begin
            mismatch_count++;
            $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        check_count++;
        if (got !== expected) begin
            mismatch_count++;
            $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    // Idle bus with no cycle in progress
    task automatic release_bus();
        address    = '0;
        wdata      = '0;
        io_read_n  = 1'b1;
        io_write_n = 1'b1;
        aen_n      = 1'b1;
        inta_n     = 1'b1;
    endtask

    function automatic bit parse_op(input string name, output op_e op);
        bit known;
        known = 1'b1;
        op    = IO_READ;
        case (name)
            "IO_WRITE":  op = IO_WRITE;
            "IO_READ":   op = IO_READ;
            "INTA":      op = INTA;
            "MEM_PROBE": op = MEM_PROBE;
            "KEY":       op = KEY;
            "FRAME":     op = FRAME;
            default:     known = 1'b0;
        endcase
        return known;
    endfunction

    // One clock of write strobe before the map is compared
    task automatic write_port(input addr_t addr, input data_t value, input logic aen,
                              input ems_map_array_t exp_map);
        @(negedge clock);
        address    = addr;
        wdata      = value;
        aen_n      = aen;
        io_write_n = 1'b0;
        @(negedge clock);
        release_bus();
        #(SETTLE_TIME);
        check_map("ems_map_o", ems_map, exp_map);
    endtask

    task automatic read_port(input addr_t addr, input data_t value, input logic aen,
                             input logic ack, input data_t exp_data, input logic exp_drive,
                             input logic [3:0] exp_cs);
        @(negedge clock);
        address   = addr;
        aen_n     = aen;
        pic_data  = value;
        pit_data  = ~value;
        io_read_n = 1'b0;
        inta_n    = !ack;
        #(SETTLE_TIME);
        check_data("data_o", rdata, exp_data);
        check_flag("data_drive_o", data_drive, exp_drive);
        check_flag("dma_cs_n_o", dma_cs_n, exp_cs[3]);
        check_flag("pic_cs_n_o", pic_cs_n, exp_cs[2]);
        check_flag("pit_cs_n_o", pit_cs_n, exp_cs[1]);
        check_flag("dma_page_cs_n_o", dma_page_cs_n, exp_cs[0]);
        @(negedge clock);
        release_bus();
    endtask

    task automatic probe_window(input addr_t addr, input ems_window_t exp_window);
        @(negedge clock);
        address = addr;
        #(SETTLE_TIME);
        check_window("ems_window_o", ems_window, exp_window);
    endtask

    task automatic apply_frame(input logic [1:0] code, input logic enable);
        @(negedge clock);
        ems_frame   = ems_frame_e'(code);
        ems_enabled = enable;
    endtask

    // New scancode and interrupt level followed by a read of port 060h
    task automatic deliver_scancode(input logic irq, input data_t code, input data_t exp_data,
                                    input data_t exp_latency);
        int cycles;
        @(negedge clock);
        keycode = code;
        kbd_irq = irq;
        cycles  = 0;
        while (kbd_irq_sync !== irq && cycles < IRQ_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (kbd_irq_sync !== irq) begin
            timeout_count++;
            $display("Timeout: keyboard_irq_o did not follow keyboard_irq_i within %0d cycles",
                     IRQ_TIMEOUT);
        end else begin
            check_data("keyboard_irq_o latency", data_t'(cycles), exp_latency);
        end
        address   = addr_t'(KBD_DATA_PORT);
        aen_n     = 1'b0;
        io_read_n = 1'b0;
        #(SETTLE_TIME);
        check_data("data_o", rdata, exp_data);
        check_flag("data_drive_o", data_drive, 1'b1);
        @(negedge clock);
        release_bus();
    endtask

    initial begin
        string       line;
        string       op_name;
        logic [31:0] field_addr;
        logic [31:0] field_data;
        logic [31:0] field_aen;
        logic [31:0] exp_1;
        logic [31:0] exp_2;
        logic [31:0] exp_3;
        op_e         op;
        int          fd;
        int          fields;
        int          bound_failures;
        reset       = 1'b1;
        release_bus();
        ems_enabled = 1'b0;
        ems_frame   = FRAME_A000;
        pic_data    = '0;
        pit_data    = '0;
        keycode     = '0;
        kbd_irq     = 1'b0;
        fd = $fopen("verif/glue_tests.txt", "r");
        if (fd == 0) begin
            file_error_count++;
            $display("Cannot open verif/glue_tests.txt, no operations were run");
        end else begin
            repeat (4) @(negedge clock);
            reset = 1'b0;
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%s %h %h %h %h %h %h", op_name, field_addr,
                                 field_data, field_aen, exp_1, exp_2, exp_3);
                if (fields < 1 || op_name.substr(0, 0) == "#") begin
                    continue;
                end
                if (fields != 7 || !parse_op(op_name, op)) begin
                    file_error_count++;
                    $display("Malformed line in tests file: %s", line);
                    continue;
                end
                case (op)
                    IO_WRITE:  write_port(field_addr[19:0], field_data[7:0], field_aen[0],
                                          exp_1[27:0]);
                    IO_READ:   read_port(field_addr[19:0], field_data[7:0], field_aen[0], 1'b0,
                                         exp_1[7:0], exp_2[0], exp_3[3:0]);
                    INTA:      read_port(field_addr[19:0], field_data[7:0], field_aen[0], 1'b1,
                                         exp_1[7:0], exp_2[0], exp_3[3:0]);
                    MEM_PROBE: probe_window(field_addr[19:0], exp_1[3:0]);
                    KEY:       deliver_scancode(field_addr[0], field_data[7:0], exp_1[7:0],
                                                exp_2[7:0]);
                    default:   apply_frame(field_addr[1:0], field_data[0]);
                endcase
            end
            $fclose(fd);
        end
        bound_failures =
            xt_peripheral_glue_inst.xt_peripheral_glue_checker_inst.assertion_failures;
        $display("Checks: %0d, mismatches: %0d, timeouts: %0d, file errors: %0d, assertions: %0d",
                 check_count, mismatch_count, timeout_count, file_error_count, bound_failures);
        if (mismatch_count == 0 && timeout_count == 0 && file_error_count == 0 &&
                bound_failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== xt_peripheral_glue.f ====
hdl/xt_bus_pkg.sv
hdl/xt_ems_pkg.sv
hdl/io_bus_if.sv
hdl/io_decode_if.sv
hdl/io_port_decoder.sv
hdl/ems_page_mapper.sv
hdl/keyboard_sync.sv
hdl/bus_read_mux.sv
hdl/xt_peripheral_glue.sv
verif/xt_peripheral_glue_checker.sv
verif/xt_peripheral_glue_tb.sv

// ==== Bender.yml ====
package:
  name: xt_peripheral_glue

sources:
  # Design sources, packages and interfaces first
  - files:
      - hdl/xt_bus_pkg.sv
      - hdl/xt_ems_pkg.sv
      - hdl/io_bus_if.sv
      - hdl/io_decode_if.sv
      - hdl/io_port_decoder.sv
      - hdl/ems_page_mapper.sv
      - hdl/keyboard_sync.sv
      - hdl/bus_read_mux.sv
      - hdl/xt_peripheral_glue.sv

  # Testbench and bound checker
  - target: test
    files:
      - verif/xt_peripheral_glue_checker.sv
      - verif/xt_peripheral_glue_tb.sv

// ==== verif/glue_tests.txt ====
# op addr data aen_n exp1 exp2 exp3, hex; reads put data on pic_data_i, ~data on pit_data_i
# IO_READ, INTA: exp1 data_o, exp2 drive, exp3 selects {dma,pic,pit,page}; IO_WRITE: exp1 map
# MEM_PROBE: exp1 window; FRAME: addr frame, data ems_enabled; KEY: addr irq, data scancode
IO_READ 00000 11 0 00 0 7
IO_READ 00020 3C 0 3C 1 B
IO_READ 00040 3C 0 C3 1 D
IO_READ 00080 55 0 00 0 E
IO_READ 00020 3C 1 00 0 F
IO_READ 00120 3C 0 00 0 F
IO_READ 000A0 3C 0 00 0 F
FRAME 0 1 0 0 0 0
IO_WRITE 00260 12 0 0000012 0 0
IO_WRITE 00261 05 0 0000292 0 0
IO_WRITE 00262 7F 0 01FC292 0 0
IO_WRITE 00263 40 0 81FC292 0 0
IO_READ 00260 00 0 12 1 F
IO_READ 00263 00 0 40 1 F
IO_WRITE 00261 90 0 81FC292 0 0
IO_READ 00261 00 0 05 1 F
IO_WRITE 00261 FF 0 81FFF92 0 0
IO_READ 00261 00 0 FF 1 F
IO_WRITE 00261 90 0 81FFF92 0 0
IO_READ 00261 00 0 FF 1 F
MEM_PROBE A4000 00 0 0 0 0
MEM_PROBE A8000 00 0 4 0 0
IO_WRITE 00261 05 0 81FC292 0 0
MEM_PROBE A4000 00 0 2 0 0
FRAME 1 1 0 0 0 0
MEM_PROBE C0000 00 0 1 0 0
MEM_PROBE A4000 00 0 0 0 0
FRAME 2 1 0 0 0 0
MEM_PROBE DC000 00 0 8 0 0
FRAME 3 1 0 0 0 0
MEM_PROBE E8000 00 0 4 0 0
FRAME 3 0 0 0 0 0
IO_WRITE 00260 33 0 81FC292 0 0
IO_READ 00260 00 0 00 0 F
FRAME 0 1 0 0 0 0
IO_WRITE 00262 01 1 81FC292 0 0
KEY 1 5A 0 5A 2 0
KEY 0 1C 0 1C 2 0
INTA 00040 A5 0 A5 1 D
INTA 000A0 77 0 77 1 F
